// File: Makefile
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= rename_unit_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src/checkpoint_table.sv
// Storage for saved rename maps.
// One full architectural-to-physical map per checkpoint slot. A snapshot
// is written at the clock edge when check is high and is read back
// combinationally at recover_idx. All slots start as the identity map.

`default_nettype none

`include "rename_defines.svh"

module checkpoint_table import rename_pkg::*; (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            check,
  input  cp_index_t                       check_idx,
  input  prf_index_t [`ARF_SIZE-1:0]      checkpoint_in,
  input  cp_index_t                       recover_idx,
  output prf_index_t [`ARF_SIZE-1:0]      checkpoint_out
);

  prf_index_t [`ARF_SIZE-1:0] snapshots [`CP_DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int c = 0; c < `CP_DEPTH; c++) begin
        for (int a = 0; a < `ARF_SIZE; a++) begin
          snapshots[c][a] <= prf_index_t'(a);
        end
      end
    end else if (check) begin
      snapshots[check_idx] <= checkpoint_in;
    end
  end

  assign checkpoint_out = snapshots[recover_idx];

endmodule

`default_nettype wire

// File: src/free_list.sv
// Free physical register list kept as a bitmap.
// Hands out the lowest free registers to the requesting slots in slot
// order, takes back registers released by commit, and reloads the whole
// bitmap on recover. allocatable says a full group can be served.

`default_nettype none

`include "rename_defines.svh"

module free_list import rename_pkg::*; (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                recover,
  input  logic [`PRF_SIZE-1:0]                recover_free,
  input  logic [`RENAME_WIDTH-1:0]            alloc_req,
  output prf_index_t [`RENAME_WIDTH-1:0]      alloc_prf,
  input  logic [`RENAME_WIDTH-1:0]            release_valid,
  input  prf_index_t [`RENAME_WIDTH-1:0]      release_prf,
  output logic                                allocatable
);

  logic [`PRF_SIZE-1:0]         free_q;
  logic [`PRF_SIZE-1:0]         free_next;
  logic [`PRF_SIZE-1:0]         avail;
  logic [`PRF_INDEX_SIZE:0]     free_count;

  function automatic prf_index_t lowest_set(input logic [`PRF_SIZE-1:0] bits);
    prf_index_t idx;
    idx = '0;
    for (int i = `PRF_SIZE - 1; i >= 0; i--) begin
      if (bits[i]) begin
        idx = prf_index_t'(i);
      end
    end
    return idx;
  endfunction

  ////////////////////////////////////////
  // Allocation
  ////////////////////////////////////////

  // A slot only takes its pick out of the pool when it asks
  always_comb begin
    avail = free_q;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      alloc_prf[s] = lowest_set(avail);
      if (alloc_req[s]) begin
        avail[alloc_prf[s]] = 1'b0;
      end
    end
  end

  always_comb begin
    free_count = '0;
    for (int i = 0; i < `PRF_SIZE; i++) begin
      free_count = free_count + {{`PRF_INDEX_SIZE{1'b0}}, free_q[i]};
    end
  end

  assign allocatable = (free_count >= `RENAME_WIDTH);

  ////////////////////////////////////////
  // Bitmap update
  ////////////////////////////////////////

  always_comb begin
    free_next = avail;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      if (release_valid[s]) begin
        free_next[release_prf[s]] = 1'b1;
      end
    end
  end

  // Registers 0 to ARF_SIZE-1 hold the identity map after reset
  always_ff @(posedge clock) begin
    if (reset) begin
      free_q <= {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};
    end else if (recover) begin
      free_q <= recover_free;
    end else begin
      free_q <= free_next;
    end
  end

endmodule

`default_nettype wire

// File: src/inst_decode.sv
// Register field decoder for one instruction word.
// Finds which architectural registers the instruction reads and writes
// from its opcode class. Unused sources come out as x0, and rd_write is
// low for instructions without a destination or with rd equal to x0.

`default_nettype none

module inst_decode import rename_pkg::*; (
  input  instr_word_t inst,
  output arf_index_t  rs1,
  output arf_index_t  rs2,
  output arf_index_t  rd,
  output logic        rd_write
);

  always_comb begin
    rs1 = '0;
    rs2 = '0;
    rd  = '0;
    case (inst.r.opcode)
      OPC_OP: begin
        rd  = inst.r.rd;
        rs1 = inst.r.rs1;
        rs2 = inst.r.rs2;
      end
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
        rd  = inst.r.rd;
        rs1 = inst.r.rs1;
      end
      // No destination, the low field is immediate
      OPC_STORE, OPC_BRANCH: begin
        rs1 = inst.s.rs1;
        rs2 = inst.s.rs2;
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL: begin
        rd = inst.r.rd;
      end
      default: begin
        rd = '0;
      end
    endcase
  end

  // x0 is never renamed
  assign rd_write = (rd != '0);

endmodule

`default_nettype wire

// File: src/mapping_table.sv
// Architectural-to-physical register map.
// Renames one group per cycle in slot order, so a later slot sees the
// destinations of the earlier ones. Asks the free list for new registers,
// saves snapshots into the checkpoint table, and reloads the map from
// it on recover. renamed marks a group that was taken.

`default_nettype none

`include "rename_defines.svh"

module mapping_table import rename_pkg::*; (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              group_valid,
  input  logic [`RENAME_WIDTH-1:0]          rd_write,
  input  arf_index_t [`RENAME_WIDTH-1:0]    rs1,
  input  arf_index_t [`RENAME_WIDTH-1:0]    rs2,
  input  arf_index_t [`RENAME_WIDTH-1:0]    rd,
  input  logic [`RENAME_WIDTH-1:0]          check_flag,
  input  cp_index_t                         check_idx,
  input  logic                              recover,
  input  cp_index_t                         recover_idx,
  input  logic [`PRF_SIZE-1:0]              recover_free,
  input  logic [`RENAME_WIDTH-1:0]          release_valid,
  input  prf_index_t [`RENAME_WIDTH-1:0]    release_prf,
  output prf_index_t [`RENAME_WIDTH-1:0]    prs1,
  output prf_index_t [`RENAME_WIDTH-1:0]    prs2,
  output prf_index_t [`RENAME_WIDTH-1:0]    prd,
  output prf_index_t [`RENAME_WIDTH-1:0]    prev_rd,
  output logic                              renamed,
  output logic                              allocatable
);

  prf_index_t [`ARF_SIZE-1:0]       map_q;
  prf_index_t [`ARF_SIZE-1:0]       map_next;
  prf_index_t [`ARF_SIZE-1:0]       snapshot;
  prf_index_t [`ARF_SIZE-1:0]       restore_map;
  prf_index_t [`RENAME_WIDTH-1:0]   alloc_prf;
  logic [`RENAME_WIDTH-1:0]         alloc_req;

  // A recover in the same cycle drops the group
  assign renamed   = group_valid & allocatable & ~recover;
  assign alloc_req = rd_write & {`RENAME_WIDTH{renamed}};

  free_list free_list_i (
    .clock         (clock),
    .reset         (reset),
    .recover       (recover),
    .recover_free  (recover_free),
    .alloc_req     (alloc_req),
    .alloc_prf     (alloc_prf),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .allocatable   (allocatable)
  );

  checkpoint_table checkpoint_table_i (
    .clock          (clock),
    .reset          (reset),
    .check          (renamed & (|check_flag)),
    .check_idx      (check_idx),
    .checkpoint_in  (snapshot),
    .recover_idx    (recover_idx),
    .checkpoint_out (restore_map)
  );

  ////////////////////////////////////////
  // Rename in slot order
  ////////////////////////////////////////

  always_comb begin
    logic taken;
    taken    = 1'b0;
    map_next = map_q;
    snapshot = map_q;
    for (int s = 0; s < `RENAME_WIDTH; s++) begin
      // Sources and old mapping come before this slot's own rename
      prs1[s]    = map_next[rs1[s]];
      prs2[s]    = map_next[rs2[s]];
      prev_rd[s] = map_next[rd[s]];
      prd[s]     = '0;
      if (rd_write[s]) begin
        prd[s]          = alloc_prf[s];
        map_next[rd[s]] = alloc_prf[s];
      end
      // Lowest flagged slot decides what the snapshot holds
      if (check_flag[s] && !taken) begin
        snapshot = map_next;
        taken    = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `ARF_SIZE; a++) begin
        map_q[a] <= prf_index_t'(a);
      end
    end else if (recover) begin
      map_q <= restore_map;
    end else if (renamed) begin
      map_q <= map_next;
    end
  end

endmodule

`default_nettype wire

// File: src/rename_defines.svh
// Sizing macros for the rename stage.
// Included by the package and by every module that sizes a port or array
// from these values. Only macros live here.

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Group and register file sizes
`define RENAME_WIDTH    2
`define ARF_SIZE        32
`define PRF_SIZE        64
`define CP_DEPTH        4

// Index widths that go with the sizes above
`define ARF_INDEX_SIZE  5
`define PRF_INDEX_SIZE  6
`define CP_INDEX_SIZE   2

`endif

// File: src/rename_pkg.sv
// Shared types for the rename stage.
// Holds the register and checkpoint index types, the major opcode
// constants, and the instruction word seen as R-type or S-type fields.
// Modules take it with a wildcard import in their header.

`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

  typedef logic [`ARF_INDEX_SIZE-1:0] arf_index_t;
  typedef logic [`PRF_INDEX_SIZE-1:0] prf_index_t;
  typedef logic [`CP_INDEX_SIZE-1:0]  cp_index_t;

  typedef logic [6:0] opcode_t;

  // RV32I major opcodes that the decoder knows about
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;

  typedef struct packed {
    logic [6:0] funct7;
    arf_index_t rs2;
    arf_index_t rs1;
    logic [2:0] funct3;
    arf_index_t rd;
    opcode_t    opcode;
  } r_fmt_t;

  // Stores and branches put immediate bits where rd sits in R-type
  typedef struct packed {
    logic [6:0] imm_hi;
    arf_index_t rs2;
    arf_index_t rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef union packed {
    r_fmt_t r;
    s_fmt_t s;
  } instr_word_t;

endpackage

`default_nettype wire

// File: src/rename_unit.sv
// Top of the rename stage.
// Decodes the two instruction words of a group and passes their register
// numbers to the mapping table, which does the renaming. Checkpoint,
// recover and release inputs go straight through to it.

`default_nettype none

`include "rename_defines.svh"

module rename_unit import rename_pkg::*; (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              group_valid,
  input  instr_word_t                       inst0,
  input  instr_word_t                       inst1,
  input  logic [`RENAME_WIDTH-1:0]          check_flag,
  input  cp_index_t                         check_idx,
  input  logic                              recover,
  input  cp_index_t                         recover_idx,
  input  logic [`PRF_SIZE-1:0]              recover_free,
  input  logic [`RENAME_WIDTH-1:0]          release_valid,
  input  prf_index_t [`RENAME_WIDTH-1:0]    release_prf,
  output prf_index_t [`RENAME_WIDTH-1:0]    prs1,
  output prf_index_t [`RENAME_WIDTH-1:0]    prs2,
  output prf_index_t [`RENAME_WIDTH-1:0]    prd,
  output prf_index_t [`RENAME_WIDTH-1:0]    prev_rd,
  output logic                              renamed,
  output logic                              allocatable
);

  arf_index_t [`RENAME_WIDTH-1:0] rs1;
  arf_index_t [`RENAME_WIDTH-1:0] rs2;
  arf_index_t [`RENAME_WIDTH-1:0] rd;
  logic [`RENAME_WIDTH-1:0]       rd_write;

  ////////////////////////////////////////
  // Decode, one per slot
  ////////////////////////////////////////

  inst_decode decode_0 (
    .inst     (inst0),
    .rs1      (rs1[0]),
    .rs2      (rs2[0]),
    .rd       (rd[0]),
    .rd_write (rd_write[0])
  );

  inst_decode decode_1 (
    .inst     (inst1),
    .rs1      (rs1[1]),
    .rs2      (rs2[1]),
    .rd       (rd[1]),
    .rd_write (rd_write[1])
  );

  mapping_table mapping_table_i (
    .clock         (clock),
    .reset         (reset),
    .group_valid   (group_valid),
    .rd_write      (rd_write),
    .rs1           (rs1),
    .rs2           (rs2),
    .rd            (rd),
    .check_flag    (check_flag),
    .check_idx     (check_idx),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .recover_free  (recover_free),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .renamed       (renamed),
    .allocatable   (allocatable)
  );

endmodule

`default_nettype wire

// File: testbench/rename_unit_tb.sv
// Testbench for the rename stage top level.
// Drives random groups, recovers and releases into rename_unit and checks
// every rename output against a reference model of map, free bitmap and
// checkpoints. Prints one line per test and a closing count line.

`default_nettype none

`include "rename_defines.svh"

module rename_unit_tb import rename_pkg::*;;

  localparam int RESET_CYCLES = 8;
  localparam int EXHAUST_MAX  = 40;
  // Cycle budget per test, then a margin on top
  localparam int MAX_CYCLES = RESET_CYCLES + 5 + 12 + EXHAUST_MAX + 2 + 10 + 9 + 5 + 1 + 20;

  logic                           clock;
  logic                           reset;
  logic                           group_valid;
  instr_word_t                    inst0;
  instr_word_t                    inst1;
  logic [`RENAME_WIDTH-1:0]       check_flag;
  cp_index_t                      check_idx;
  logic                           recover;
  cp_index_t                      recover_idx;
  logic [`PRF_SIZE-1:0]           recover_free;
  logic [`RENAME_WIDTH-1:0]       release_valid;
  prf_index_t [`RENAME_WIDTH-1:0] release_prf;
  prf_index_t [`RENAME_WIDTH-1:0] prs1;
  prf_index_t [`RENAME_WIDTH-1:0] prs2;
  prf_index_t [`RENAME_WIDTH-1:0] prd;
  prf_index_t [`RENAME_WIDTH-1:0] prev_rd;
  logic                           renamed;
  logic                           allocatable;

  // Reference model state
  prf_index_t           m_map [`ARF_SIZE];
  prf_index_t           m_snap [`CP_DEPTH][`ARF_SIZE];
  logic [`PRF_SIZE-1:0] m_free;
  prf_index_t           retire_q [$];

  integer seed = 77746;
  int     cycle_count = 0;
  int     checks = 0;
  int     errors = 0;
  int     tests = 0;
  int     test_checks0;
  int     test_errors0;

  rename_unit dut_i (
    .clock         (clock),
    .reset         (reset),
    .group_valid   (group_valid),
    .inst0         (inst0),
    .inst1         (inst1),
    .check_flag    (check_flag),
    .check_idx     (check_idx),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .recover_free  (recover_free),
    .release_valid (release_valid),
    .release_prf   (release_prf),
    .prs1          (prs1),
    .prs2          (prs2),
    .prd           (prd),
    .prev_rd       (prev_rd),
    .renamed       (renamed),
    .allocatable   (allocatable)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks and reporting
  ////////////////////////////////////////

  task automatic check_prf(input string name, input prf_index_t exp, input prf_index_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic begin_test();
    test_checks0 = checks;
    test_errors0 = errors;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("%-20s finished: %0d checks, %0d errors", name,
             checks - test_checks0, errors - test_errors0);
  endtask

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////

  // Register usage by opcode class, fields at their RV32I bit positions
  task automatic model_decode(input logic [31:0] w, output arf_index_t s1,
                              output arf_index_t s2, output arf_index_t d,
                              output logic wr);
    s1 = '0;
    s2 = '0;
    d  = '0;
    if (w[6:0] == OPC_OP) begin
      d  = w[11:7];
      s1 = w[19:15];
      s2 = w[24:20];
    end else if (w[6:0] inside {OPC_OP_IMM, OPC_LOAD, OPC_JALR}) begin
      d  = w[11:7];
      s1 = w[19:15];
    end else if (w[6:0] inside {OPC_STORE, OPC_BRANCH}) begin
      s1 = w[19:15];
      s2 = w[24:20];
    end else if (w[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL}) begin
      d = w[11:7];
    end
    wr = (d != 0);
  endtask

  function automatic prf_index_t first_free(input logic [`PRF_SIZE-1:0] f);
    for (int i = 0; i < `PRF_SIZE; i++) begin
      if (f[i]) begin
        return prf_index_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic int free_count(input logic [`PRF_SIZE-1:0] f);
    int n;
    n = 0;
    for (int i = 0; i < `PRF_SIZE; i++) begin
      n += int'(f[i]);
    end
    return n;
  endfunction

  function automatic arf_index_t rand_reg(input logic nonzero);
    arf_index_t r;
    r = arf_index_t'($random(seed));
    if (nonzero && r == 0) begin
      r = 5'd1;
    end
    return r;
  endfunction

  function automatic instr_word_t make_r(input opcode_t op, input arf_index_t d,
                                         input arf_index_t s1, input arf_index_t s2);
    instr_word_t w;
    w = '0;
    w.r.opcode = op;
    w.r.rd     = d;
    w.r.rs1    = s1;
    w.r.rs2    = s2;
    return w;
  endfunction

  function automatic instr_word_t make_s(input opcode_t op, input arf_index_t s1,
                                         input arf_index_t s2, input logic [11:0] imm);
    instr_word_t w;
    w = '0;
    w.s.opcode = op;
    w.s.imm_lo = imm[4:0];
    w.s.imm_hi = imm[11:5];
    w.s.rs1    = s1;
    w.s.rs2    = s2;
    return w;
  endfunction

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // One cycle of stimulus, then check at mid cycle and advance the model
  task automatic drive_group(input string name, input logic gv, input instr_word_t w0,
                             input instr_word_t w1, input logic [1:0] cflag,
                             input cp_index_t cidx, input logic use_rel);
    instr_word_t          w;
    arf_index_t           s1;
    arf_index_t           s2;
    arf_index_t           d;
    logic                 wr;
    logic                 acc;
    logic                 saved;
    logic [1:0]           rv;
    prf_index_t           rp [2];
    prf_index_t           ep;
    logic [`PRF_SIZE-1:0] work;
    rv    = 2'b00;
    rp[0] = '0;
    rp[1] = '0;
    if (use_rel && retire_q.size() >= 2) begin
      rv    = 2'b11;
      rp[0] = retire_q.pop_front();
      rp[1] = retire_q.pop_front();
    end
    @(posedge clock);
    group_valid    <= gv;
    inst0          <= w0;
    inst1          <= w1;
    check_flag     <= cflag;
    check_idx      <= cidx;
    recover        <= 1'b0;
    release_valid  <= rv;
    release_prf[0] <= rp[0];
    release_prf[1] <= rp[1];
    @(negedge clock);
    acc = gv && (free_count(m_free) >= 2);
    check_flag_bit({name, " allocatable"}, free_count(m_free) >= 2, allocatable);
    check_flag_bit({name, " renamed"}, acc, renamed);
    work  = m_free;
    saved = 1'b0;
    if (acc) begin
      for (int s = 0; s < 2; s++) begin
        w = (s == 0) ? w0 : w1;
        model_decode(w, s1, s2, d, wr);
        check_prf($sformatf("%s prs1[%0d]", name, s), m_map[s1], prs1[s]);
        check_prf($sformatf("%s prs2[%0d]", name, s), m_map[s2], prs2[s]);
        check_prf($sformatf("%s prev_rd[%0d]", name, s), m_map[d], prev_rd[s]);
        ep = '0;
        if (wr) begin
          ep       = first_free(work);
          work[ep] = 1'b0;
          retire_q.push_back(m_map[d]);
          m_map[d] = ep;
        end
        check_prf($sformatf("%s prd[%0d]", name, s), ep, prd[s]);
        if (cflag[s] && !saved) begin
          for (int a = 0; a < `ARF_SIZE; a++) begin
            m_snap[cidx][a] = m_map[a];
          end
          saved = 1'b1;
        end
      end
    end
    m_free = work;
    for (int s = 0; s < 2; s++) begin
      if (rv[s]) begin
        m_free[rp[s]] = 1'b1;
      end
    end
  endtask

  // Recover with a group in the same cycle, which must be dropped
  task automatic drive_recover(input string name, input cp_index_t idx,
                               input instr_word_t w0, input instr_word_t w1);
    logic [`PRF_SIZE-1:0] restored_free;
    restored_free = m_free;
    // Registers renamed since the checkpoint go back to the pool
    for (int a = 0; a < `ARF_SIZE; a++) begin
      if (m_map[a] != m_snap[idx][a]) begin
        restored_free[m_map[a]] = 1'b1;
      end
    end
    @(posedge clock);
    recover       <= 1'b1;
    recover_idx   <= idx;
    recover_free  <= restored_free;
    group_valid   <= 1'b1;
    inst0         <= w0;
    inst1         <= w1;
    check_flag    <= 2'b00;
    release_valid <= 2'b00;
    @(negedge clock);
    check_flag_bit({name, " renamed during recover"}, 1'b0, renamed);
    m_free = restored_free;
    for (int a = 0; a < `ARF_SIZE; a++) begin
      m_map[a] = m_snap[idx][a];
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    instr_word_t w0;
    instr_word_t w1;
    arf_index_t  r;
    opcode_t     op;
    int          n;
    reset         = 1'b1;
    group_valid   = 1'b0;
    inst0         = '0;
    inst1         = '0;
    check_flag    = '0;
    check_idx     = '0;
    recover       = 1'b0;
    recover_idx   = '0;
    recover_free  = '0;
    release_valid = '0;
    release_prf   = '0;
    for (int a = 0; a < `ARF_SIZE; a++) begin
      m_map[a] = prf_index_t'(a);
      for (int c = 0; c < `CP_DEPTH; c++) begin
        m_snap[c][a] = prf_index_t'(a);
      end
    end
    m_free = {{(`PRF_SIZE - `ARF_SIZE){1'b1}}, {`ARF_SIZE{1'b0}}};
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    begin_test();
    drive_group("reset_map idle", 1'b0, '0, '0, 2'b00, 2'd0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      w0 = make_s(OPC_STORE, rand_reg(1'b0), rand_reg(1'b0), 12'($random(seed)));
      w1 = make_s(OPC_STORE, rand_reg(1'b0), rand_reg(1'b0), 12'($random(seed)));
      drive_group("reset_map", 1'b1, w0, w1, 2'b00, 2'd0, 1'b0);
    end
    report_test("reset_map");

    begin_test();
    for (int i = 0; i < 12; i++) begin
      op = ($random(seed) & 1) ? OPC_OP : OPC_OP_IMM;
      r  = rand_reg(1'b0);
      w0 = make_r(op, r, rand_reg(1'b0), rand_reg(1'b0));
      // Every third group reuses slot 0's rd as destination and source
      if (i % 3 == 0) begin
        w1 = make_r(OPC_OP, r, r, rand_reg(1'b0));
      end else begin
        w1 = make_r(op, rand_reg(1'b0), rand_reg(1'b0), r);
      end
      drive_group("alloc_order", 1'b1, w0, w1, 2'b00, 2'd0, 1'b0);
    end
    report_test("alloc_order");

    begin_test();
    n = 0;
    while (free_count(m_free) >= 2 && n < EXHAUST_MAX) begin
      w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      w1 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      drive_group("exhaust", 1'b1, w0, w1, 2'b00, 2'd0, 1'b0);
      n++;
    end
    if (free_count(m_free) >= 2) begin
      errors++;
      $display("exhaust: free registers never ran out after %0d groups", n);
    end
    repeat (2) begin
      w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      drive_group("exhaust blocked", 1'b1, w0, w0, 2'b00, 2'd0, 1'b0);
    end
    report_test("exhaust");

    begin_test();
    repeat (6) drive_group("release idle", 1'b0, '0, '0, 2'b00, 2'd0, 1'b1);
    repeat (4) begin
      w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      w1 = make_r(OPC_OP_IMM, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      drive_group("release", 1'b1, w0, w1, 2'b00, 2'd0, 1'b0);
    end
    report_test("release");

    begin_test();
    w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    w1 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    drive_group("checkpoint slot0", 1'b1, w0, w1, 2'b01, 2'd1, 1'b1);
    w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    drive_group("checkpoint slot1", 1'b1, w0, w1, 2'b10, 2'd2, 1'b1);
    repeat (3) begin
      w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      w1 = make_r(OPC_LOAD, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      drive_group("checkpoint random", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    end
    for (int k = 1; k <= 2; k++) begin
      drive_recover("recover", cp_index_t'(k), w0, w1);
      w0 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      w1 = make_r(OPC_OP, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
      drive_group("after recover", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    end
    report_test("checkpoint_recover");

    begin_test();
    w0 = make_s(OPC_STORE, rand_reg(1'b0), rand_reg(1'b0), 12'($random(seed)));
    w1 = make_s(OPC_BRANCH, rand_reg(1'b0), rand_reg(1'b0), 12'($random(seed)));
    drive_group("store branch", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    w0 = make_r(OPC_LUI, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    w1 = make_r(OPC_OP, 5'd0, rand_reg(1'b0), rand_reg(1'b0));
    drive_group("lui rd_x0", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    w0 = make_r(7'b1111111, rand_reg(1'b1), rand_reg(1'b1), rand_reg(1'b1));
    w1 = make_r(OPC_JAL, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    drive_group("unknown jal", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    w0 = make_r(OPC_LOAD, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    w1 = make_r(OPC_AUIPC, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    drive_group("load auipc", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    w0 = make_r(OPC_JALR, rand_reg(1'b1), rand_reg(1'b0), rand_reg(1'b0));
    w1 = make_r(OPC_OP_IMM, 5'd0, rand_reg(1'b0), rand_reg(1'b0));
    drive_group("jalr op_imm_x0", 1'b1, w0, w1, 2'b00, 2'd0, 1'b1);
    report_test("decode_classes");

    drive_group("final idle", 1'b0, '0, '0, 2'b00, 2'd0, 1'b0);
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/rename_pkg.sv
src/inst_decode.sv
src/free_list.sv
src/checkpoint_table.sv
src/mapping_table.sv
src/rename_unit.sv
testbench/rename_unit_tb.sv
